// File: common/muldiv_pkg.sv
// ================================================
// muldiv_pkg: shared widths, opcodes, latencies and
// bus structs of the RV32M multiply/divide block
// ================================================
package muldiv_pkg;

    // data and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // opcode follows funct3, top bit marks the divide class
    typedef logic [2:0] muldiv_op_t;

    localparam muldiv_op_t OP_MUL    = 3'b000;
    localparam muldiv_op_t OP_MULH   = 3'b001;
    localparam muldiv_op_t OP_MULHSU = 3'b010;
    localparam muldiv_op_t OP_MULHU  = 3'b011;
    localparam muldiv_op_t OP_DIV    = 3'b100;
    localparam muldiv_op_t OP_DIVU   = 3'b101;
    localparam muldiv_op_t OP_REM    = 3'b110;
    localparam muldiv_op_t OP_REMU   = 3'b111;

    // edges from operand capture to the done pulse
    localparam int MUL_LAT  = 2;
    localparam int DIV_LAT  = 33;
    // shift-subtract steps, the last edge is the fix-up
    localparam int DIV_ITER = DIV_LAT - 1;

    typedef logic [$clog2(DIV_ITER)-1:0] div_cnt_t;

    // request as dispatched
    typedef struct packed {
        logic       valid;
        muldiv_op_t op;
        xlen_t      rs1_data;
        xlen_t      rs2_data;
        reg_addr_t  rd;
    } muldiv_req_t;

    // operands shared by both units
    typedef struct packed {
        muldiv_op_t op;
        xlen_t      a;
        xlen_t      b;
        reg_addr_t  rd;
    } unit_req_t;

    // unit result, done is a single-cycle pulse
    typedef struct packed {
        logic      done;
        xlen_t     data;
        reg_addr_t rd;
    } unit_rsp_t;

    // register write-back port
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
    } muldiv_wb_t;

endpackage

// File: exu_muldiv_ctrl/exu_muldiv_ctrl.sv
// ================================================
// exu_muldiv_ctrl: decodes the request, starts a unit,
// holds dispatch and selects the write-back
// ================================================
module exu_muldiv_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    // dispatch side
    input  muldiv_pkg::muldiv_req_t req_i,
    input  logic                   int_assert_i,

    // unit results
    input  muldiv_pkg::unit_rsp_t  mul_rsp_i,
    input  muldiv_pkg::unit_rsp_t  div_rsp_i,

    // unit control
    output muldiv_pkg::unit_req_t  unit_req_o,
    output logic                   mul_start_o,
    output logic                   div_start_o,
    output logic                   kill_o,

    // pipeline hold and register write-back
    output logic                   hold_o,
    output muldiv_pkg::muldiv_wb_t wb_o
);

    typedef enum logic {
        IDLE,
        WAIT
    } state_t;

    state_t state_q;
    state_t state_d;

    logic is_div;
    logic launch;
    logic in_wait;
    logic done_any;
    logic wb_fire;

    // top opcode bit picks the divider
    assign is_div  = req_i.op[2];
    assign in_wait = (state_q == WAIT);

    // launch only from idle, one op in flight
    assign launch      = (state_q == IDLE) && req_i.valid;
    assign mul_start_o = launch && !is_div;
    assign div_start_o = launch && is_div;

    // operands go straight to both units
    assign unit_req_o.op = req_i.op;
    assign unit_req_o.a  = req_i.rs1_data;
    assign unit_req_o.b  = req_i.rs2_data;
    assign unit_req_o.rd = req_i.rd;

    // interrupt cancels whatever is running
    assign kill_o = in_wait && int_assert_i;

    assign done_any = mul_rsp_i.done || div_rsp_i.done;
    assign wb_fire  = in_wait && done_any && !int_assert_i;

    // write-back taken from whichever unit finished
    assign wb_o.we   = wb_fire;
    assign wb_o.rd   = mul_rsp_i.done ? mul_rsp_i.rd : div_rsp_i.rd;
    assign wb_o.data = mul_rsp_i.done ? mul_rsp_i.data : div_rsp_i.data;

    // hold from request until the write-back cycle
    // released early on a cancel
    assign hold_o = launch || (in_wait && !done_any && !int_assert_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (launch) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                // cancel or finish both end the op
                if (kill_o || wb_fire) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: exu_mul/exu_mul.sv
// ================================================
// exu_mul: pipelined 32x32 multiplier, low or high word
// ================================================
module exu_mul (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    input  logic                  kill_i,
    input  muldiv_pkg::unit_req_t req_i,
    output muldiv_pkg::unit_rsp_t rsp_o
);

    localparam int XLEN = muldiv_pkg::XLEN;

    // operand capture
    logic                  s0_valid;
    muldiv_pkg::muldiv_op_t s0_op;
    muldiv_pkg::xlen_t     s0_a;
    muldiv_pkg::xlen_t     s0_b;
    muldiv_pkg::reg_addr_t s0_rd;

    // stage one, full product
    logic                  s1_valid;
    logic                  s1_hi_sel;
    logic [2*XLEN-1:0]     s1_prod;
    muldiv_pkg::reg_addr_t s1_rd;

    // stage two, selected word
    logic                  done_q;
    muldiv_pkg::xlen_t     data_q;
    muldiv_pkg::reg_addr_t rd_q;

    logic                     a_sign;
    logic                     b_sign;
    logic signed [XLEN:0]     a_ext;
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN+1:0] prod_full;

    // rs1 signed for MULH and MULHSU, rs2 signed for MULH only
    assign a_sign = ((s0_op == muldiv_pkg::OP_MULH) || (s0_op == muldiv_pkg::OP_MULHSU))
                    && s0_a[XLEN-1];
    assign b_sign = (s0_op == muldiv_pkg::OP_MULH) && s0_b[XLEN-1];

    // 33-bit operands cover every sign mix with one signed multiply
    assign a_ext     = {a_sign, s0_a};
    assign b_ext     = {b_sign, s0_b};
    assign prod_full = a_ext * b_ext;

    // valid chain, cleared on reset or cancel
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || kill_i) begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            s0_valid <= start_i;
            s1_valid <= s0_valid;
            done_q   <= s1_valid;
        end
    end

    // payload pipeline
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            s0_op <= req_i.op;
            s0_a  <= req_i.a;
            s0_b  <= req_i.b;
            s0_rd <= req_i.rd;
        end
        s1_hi_sel <= (s0_op != muldiv_pkg::OP_MUL);
        s1_prod   <= prod_full[2*XLEN-1:0];
        s1_rd     <= s0_rd;
        // MUL keeps the low word, the rest the high word
        data_q    <= s1_hi_sel ? s1_prod[2*XLEN-1:XLEN] : s1_prod[XLEN-1:0];
        rd_q      <= s1_rd;
    end

    // no done in a cancelled cycle
    assign rsp_o.done = done_q && !kill_i;
    assign rsp_o.data = data_q;
    assign rsp_o.rd   = rd_q;

endmodule

// File: exu_div/exu_div.sv
// ================================================
// exu_div: radix-2 restoring divider with sign fix-up
// and RV32M divide-by-zero / overflow results
// ================================================
module exu_div (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    input  logic                  kill_i,
    input  muldiv_pkg::unit_req_t req_i,
    output muldiv_pkg::unit_rsp_t rsp_o
);

    localparam int XLEN = muldiv_pkg::XLEN;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        FIX
    } state_t;

    // control
    state_t               state_q;
    muldiv_pkg::div_cnt_t cnt_q;
    logic                 done_q;

    // datapath
    muldiv_pkg::xlen_t     rem_q;
    muldiv_pkg::xlen_t     quo_q;
    muldiv_pkg::xlen_t     dvs_q;
    muldiv_pkg::xlen_t     dividend_q;
    muldiv_pkg::reg_addr_t rd_q;
    logic                  rem_sel_q;
    logic                  neg_quo_q;
    logic                  neg_rem_q;
    logic                  div_zero_q;
    logic                  ovf_q;
    muldiv_pkg::xlen_t     data_q;
    muldiv_pkg::reg_addr_t rsp_rd_q;

    logic              is_signed;
    logic              neg_a;
    logic              neg_b;
    muldiv_pkg::xlen_t abs_a;
    muldiv_pkg::xlen_t abs_b;
    logic [XLEN:0]     trial;
    logic [XLEN:0]     diff;
    logic              sub_ok;
    muldiv_pkg::xlen_t quo_fix;
    muldiv_pkg::xlen_t rem_fix;

    // DIV and REM have op[0] clear
    assign is_signed = !req_i.op[0];
    assign neg_a     = is_signed && req_i.a[XLEN-1];
    assign neg_b     = is_signed && req_i.b[XLEN-1];
    assign abs_a     = neg_a ? -req_i.a : req_i.a;
    assign abs_b     = neg_b ? -req_i.b : req_i.b;

    // shift in next dividend bit and try the subtract
    assign trial  = {rem_q, quo_q[XLEN-1]};
    assign diff   = trial - {1'b0, dvs_q};
    assign sub_ok = !diff[XLEN];

    // restore signs, then the special cases win
    always_comb begin
        quo_fix = neg_quo_q ? -quo_q : quo_q;
        rem_fix = neg_rem_q ? -rem_q : rem_q;
        if (div_zero_q) begin
            quo_fix = '1;
            rem_fix = dividend_q;
        end else if (ovf_q) begin
            quo_fix = {1'b1, {(XLEN-1){1'b0}}};
            rem_fix = '0;
        end
    end

    // state, counter and done pulse
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || kill_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= CALC;
                        cnt_q   <= '0;
                    end
                end
                CALC: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == muldiv_pkg::div_cnt_t'(muldiv_pkg::DIV_ITER - 1)) begin
                        state_q <= FIX;
                    end
                end
                FIX: begin
                    state_q <= IDLE;
                    done_q  <= 1'b1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // operand capture, iterations and result
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            rem_q      <= '0;
            quo_q      <= abs_a;
            dvs_q      <= abs_b;
            dividend_q <= req_i.a;
            rd_q       <= req_i.rd;
            rem_sel_q  <= req_i.op[1];
            neg_quo_q  <= neg_a ^ neg_b;
            neg_rem_q  <= neg_a;
            div_zero_q <= (req_i.b == '0);
            // most negative over -1
            ovf_q      <= is_signed && (req_i.a == {1'b1, {(XLEN-1){1'b0}}})
                          && (req_i.b == '1);
        end else if (state_q == CALC) begin
            rem_q <= sub_ok ? diff[XLEN-1:0] : trial[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], sub_ok};
        end
        if (state_q == FIX) begin
            data_q   <= rem_sel_q ? rem_fix : quo_fix;
            rsp_rd_q <= rd_q;
        end
    end

    // no done in a cancelled cycle
    assign rsp_o.done = done_q && !kill_i;
    assign rsp_o.data = data_q;
    assign rsp_o.rd   = rsp_rd_q;

endmodule

// File: verilog/exu_muldiv.sv
// ================================================
// exu_muldiv: RV32M execution block, control plus units
// ================================================
module exu_muldiv (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  muldiv_pkg::muldiv_req_t req_i,
    input  logic                   int_assert_i,
    output logic                   hold_o,
    output muldiv_pkg::muldiv_wb_t wb_o
);

    // shared operands and per-unit strobes
    muldiv_pkg::unit_req_t unit_req;
    logic                  mul_start;
    logic                  div_start;
    logic                  kill;

    // unit results back to control
    muldiv_pkg::unit_rsp_t mul_rsp;
    muldiv_pkg::unit_rsp_t div_rsp;

    exu_muldiv_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .int_assert_i (int_assert_i),
        .mul_rsp_i    (mul_rsp),
        .div_rsp_i    (div_rsp),
        .unit_req_o   (unit_req),
        .mul_start_o  (mul_start),
        .div_start_o  (div_start),
        .kill_o       (kill),
        .hold_o       (hold_o),
        .wb_o         (wb_o)
    );

    exu_mul u_mul (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (mul_start),
        .kill_i  (kill),
        .req_i   (unit_req),
        .rsp_o   (mul_rsp)
    );

    exu_div u_div (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (div_start),
        .kill_i  (kill),
        .req_i   (unit_req),
        .rsp_o   (div_rsp)
    );

endmodule

// File: test/exu_muldiv_chk.sv
// ================================================
// exu_muldiv_chk: assertions on the unit strobes,
// hold and write-back of the muldiv control
// ================================================
module exu_muldiv_chk (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   mul_start_i,
    input logic                   div_start_i,
    input logic                   hold_i,
    input logic                   in_wait_i,
    input muldiv_pkg::muldiv_wb_t wb_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // start strobes are single-cycle pulses
    mul_start_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mul_start_i |=> !mul_start_i)
        else $error("mul start held for more than one cycle");

    div_start_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        div_start_i |=> !div_start_i)
        else $error("div start held for more than one cycle");

    // never both units at once
    start_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(mul_start_i && div_start_i))
        else $error("mul and div start high together");

    // write-back only while an op is in flight
    we_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_i.we |-> in_wait_i)
        else $error("write-back outside WAIT");

    // dispatch released in the write-back cycle
    we_no_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_i.we |-> !hold_i)
        else $error("hold high during write-back");

    // quiet while reset is held
    reset_quiet: assert property (@(posedge clk_i)
        (!rst_n_i && !$past(rst_n_i)) |->
        (!wb_i.we && !hold_i && !mul_start_i && !div_start_i && !in_wait_i))
        else $error("control active during reset");

endmodule

bind exu_muldiv_ctrl exu_muldiv_chk u_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mul_start_i (mul_start_o),
    .div_start_i (div_start_o),
    .hold_i      (hold_o),
    .in_wait_i   (in_wait),
    .wb_i        (wb_o)
);

// File: test/tb_exu_muldiv.sv
// ================================================
// tb_exu_muldiv: table driven test of the RV32M block
// against a reference model of the RV32M rules
// ================================================
module tb_exu_muldiv;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        muldiv_pkg::muldiv_op_t op;
        muldiv_pkg::xlen_t      a;
        muldiv_pkg::xlen_t      b;
        logic                   rnd;
        logic                   is_div;
        int                     irq_cyc;
    } test_t;

    localparam int NUM_TESTS = 32;

    logic                    clk;
    logic                    rst_n;
    muldiv_pkg::muldiv_req_t req;
    logic                    int_assert;
    logic                    hold;
    muldiv_pkg::muldiv_wb_t  wb;

    int                err_cnt = 0;
    int                wb_seen = 0;
    int                wb_exp = 0;
    muldiv_pkg::xlen_t lcg_state = 32'h4d99_0541;

    // op, a, b, random operands, divide class, cancel cycle (-1 none)
    test_t tests [NUM_TESTS] = '{
        '{muldiv_pkg::OP_MUL,    32'h0000_0007, 32'h0000_0006, 1'b0, 1'b0, -1},
        '{muldiv_pkg::OP_MUL,    32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0, -1},
        '{muldiv_pkg::OP_MULH,   32'h8000_0000, 32'h8000_0000, 1'b0, 1'b0, -1},
        '{muldiv_pkg::OP_MULH,   32'hffff_ffff, 32'h7fff_ffff, 1'b0, 1'b0, -1},
        '{muldiv_pkg::OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0, -1},
        '{muldiv_pkg::OP_MULHSU, 32'h8000_0000, 32'h0000_0002, 1'b0, 1'b0, -1},
        '{muldiv_pkg::OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0, -1},
        '{muldiv_pkg::OP_MUL,    32'h0,         32'h0,         1'b1, 1'b0, -1},
        '{muldiv_pkg::OP_MULH,   32'h0,         32'h0,         1'b1, 1'b0, -1},
        '{muldiv_pkg::OP_MULHSU, 32'h0,         32'h0,         1'b1, 1'b0, -1},
        '{muldiv_pkg::OP_MULHU,  32'h0,         32'h0,         1'b1, 1'b0, -1},
        '{muldiv_pkg::OP_DIV,    32'hffff_fff9, 32'h0000_0002, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_DIV,    32'h0000_0007, 32'hffff_fffe, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_DIVU,   32'hffff_fff9, 32'h0000_0002, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_REM,    32'hffff_fff9, 32'h0000_0002, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_REMU,   32'h0000_0064, 32'h0000_0007, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_DIV,    32'h0,         32'h0,         1'b1, 1'b1, -1},
        '{muldiv_pkg::OP_DIVU,   32'h0,         32'h0,         1'b1, 1'b1, -1},
        '{muldiv_pkg::OP_REM,    32'h0,         32'h0,         1'b1, 1'b1, -1},
        '{muldiv_pkg::OP_REMU,   32'h0,         32'h0,         1'b1, 1'b1, -1},
        '{muldiv_pkg::OP_DIV,    32'h1234_5678, 32'h0000_0000, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_DIVU,   32'h8765_4321, 32'h0000_0000, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_REM,    32'hffff_fff0, 32'h0000_0000, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_REMU,   32'h8000_0000, 32'h0000_0000, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_DIV,    32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_REM,    32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_DIVU,   32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_REMU,   32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b1, -1},
        '{muldiv_pkg::OP_MULHU,  32'h0,         32'h0,         1'b1, 1'b0, 0},
        '{muldiv_pkg::OP_MUL,    32'h0000_0003, 32'h0000_0005, 1'b0, 1'b0, -1},
        '{muldiv_pkg::OP_DIV,    32'h0,         32'h0,         1'b1, 1'b1, 10},
        '{muldiv_pkg::OP_REM,    32'h0000_0064, 32'h0000_0007, 1'b0, 1'b1, -1}
    };

    exu_muldiv dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .req_i        (req),
        .int_assert_i (int_assert),
        .hold_o       (hold),
        .wb_o         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // every write-back pulse, counted mid-cycle
    always @(negedge clk) begin
        if (wb.we === 1'b1) begin
            wb_seen++;
        end
    end

    function automatic muldiv_pkg::xlen_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected result straight from the RV32M rules
    function automatic muldiv_pkg::xlen_t model_result(input muldiv_pkg::muldiv_op_t op,
                                                       input muldiv_pkg::xlen_t a,
                                                       input muldiv_pkg::xlen_t b);
        longint      sa;
        longint      sb;
        logic [63:0] ua;
        logic [63:0] ub;
        logic [63:0] prod;
        logic        ovf;
        sa  = longint'($signed(a));
        sb  = longint'($signed(b));
        ua  = {32'h0, a};
        ub  = {32'h0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            muldiv_pkg::OP_MULH:   prod = sa * sb;
            muldiv_pkg::OP_MULHSU: prod = sa * longint'(ub);
            default:               prod = ua * ub;
        endcase
        case (op)
            muldiv_pkg::OP_MUL:  return prod[31:0];
            muldiv_pkg::OP_DIV:  return (b == 0) ? 32'hffff_ffff : ovf ? a
                                        : muldiv_pkg::xlen_t'(sa / sb);
            muldiv_pkg::OP_DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
            muldiv_pkg::OP_REM:  return (b == 0) ? a : ovf ? 32'h0
                                        : muldiv_pkg::xlen_t'(sa % sb);
            muldiv_pkg::OP_REMU: return (b == 0) ? a : a % b;
            default:             return prod[63:32];
        endcase
    endfunction

    task automatic check_data(input muldiv_pkg::xlen_t got, input muldiv_pkg::xlen_t exp,
                              input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_rd(input muldiv_pkg::reg_addr_t got,
                            input muldiv_pkg::reg_addr_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got x%0d expected x%0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_lat(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERR %0t: %s got %0d edges expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // one request from dispatch to write-back or cancel
    task automatic run_test(input int idx);
        test_t                 t;
        muldiv_pkg::xlen_t     a;
        muldiv_pkg::xlen_t     b;
        muldiv_pkg::reg_addr_t rd;
        muldiv_pkg::xlen_t     exp_data;
        int                    exp_lat;
        int                    n;
        int                    errs_before;
        bit                    finished;
        t           = tests[idx];
        errs_before = err_cnt;
        a           = t.rnd ? lcg_next() : t.a;
        b           = t.rnd ? lcg_next() : t.b;
        rd          = muldiv_pkg::reg_addr_t'(idx + 1);
        exp_data    = model_result(t.op, a, b);
        exp_lat     = t.is_div ? muldiv_pkg::DIV_LAT : muldiv_pkg::MUL_LAT;
        n           = 0;
        finished    = 1'b0;
        @(posedge clk);
        #1;
        int_assert = 1'b0;
        req = '{valid: 1'b1, op: t.op, rs1_data: a, rs2_data: b, rd: rd};
        // request cycle, dispatch already held
        @(negedge clk);
        check_level(hold, 1'b1, "hold in request cycle");
        check_level(wb.we, 1'b0, "we in request cycle");
        // n counts edges after E0
        while (!finished && n <= exp_lat + 8) begin
            @(posedge clk);
            #1;
            int_assert = (n == t.irq_cyc);
            @(negedge clk);
            if (n == t.irq_cyc) begin
                check_level(hold, 1'b0, "hold in cancel cycle");
                check_level(wb.we, 1'b0, "we in cancel cycle");
                finished = 1'b1;
            end else if (wb.we === 1'b1) begin
                check_lat(n, exp_lat, "write-back latency");
                check_data(wb.data, exp_data, "write-back data");
                check_rd(wb.rd, rd, "write-back rd")
                ;
                check_level(hold, 1'b0, "hold in write-back cycle");
                finished = 1'b1;
            end else begin
                check_level(hold, 1'b1, "hold while busy");
            end
            n++;
        end
        if (!finished) begin
            $display("timeout: test %0d never reached write-back", idx);
            err_cnt++;
        end
        // a cancelled op is followed at once by the next request,
        // so a unit left running shows up as a stray write-back
        if (t.irq_cyc < 0) begin
            wb_exp++;
        end
        $display("test %0d op %0d rd x%0d %s", idx, t.op, rd,
                 (err_cnt == errs_before) ? "ok" : "bad");
    endtask

    initial begin
        rst_n      = 1'b0;
        req        = '0;
        int_assert = 1'b0;
        // 4 edges in reset, then two quiet cycles
        for (int c = 0; c < 6; c++) begin
            @(posedge clk);
            #1;
            if (c == 3) begin
                rst_n = 1'b1;
            end
            @(negedge clk);
            check_level(wb.we, 1'b0, "we around reset");
            check_level(hold, 1'b0, "hold around reset");
        end
        $display("reset test %s", (err_cnt == 0) ? "ok" : "bad");
        // back to back, each starts on the edge after the last write-back
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        @(posedge clk);
        #1;
        int_assert = 1'b0;
        req.valid  = 1'b0;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
        end
        check_count(wb_seen, wb_exp, "write-back pulses");
        $display("tests %0d errors %0d write-backs %0d", NUM_TESTS, err_cnt, wb_seen);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
common/muldiv_pkg.sv
exu_muldiv_ctrl/exu_muldiv_ctrl.sv
exu_mul/exu_mul.sv
exu_div/exu_div.sv
verilog/exu_muldiv.sv
test/exu_muldiv_chk.sv
test/tb_exu_muldiv.sv
